/* design/soc_node_pkg.sv */
/*
 * soc node shared definitions
 * port counts, widths, the address map, id widening and channel structs
 * used by every block of the four-initiator, three-target node
 */
`default_nettype none

package soc_node_pkg;

  // initiators: cluster, c07, nocr07, sms
  localparam int unsigned n_ini = 4;
  // targets: soc, c07, nocr07
  localparam int unsigned n_tgt = 3;
  // response sources seen by a router, the error target comes last
  localparam int unsigned n_src = n_tgt + 1;

  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned ini_w  = $clog2(n_ini);
  localparam int unsigned iw_inp = 4;

  // target side id carries the initiator index on top
  function automatic int unsigned oup_id_width(input int unsigned iw);
    return iw + $clog2(n_ini);
  endfunction

  localparam int unsigned iw_oup = oup_id_width(iw_inp);

  typedef logic [ini_w-1:0] ini_idx_t;
  typedef logic [$clog2(n_src)-1:0] src_idx_t;
  typedef logic [1:0] dest_t;

  // decode results
  localparam dest_t tgt_soc    = 2'd0;
  localparam dest_t tgt_c07    = 2'd1;
  localparam dest_t tgt_nocr07 = 2'd2;
  localparam dest_t dest_none  = 2'd3;
  localparam src_idx_t src_err = src_idx_t'(n_tgt);

  // inclusive ranges, everything below soc_start is unmapped
  localparam logic [addr_w-1:0] soc_start    = 32'h1A00_0000;
  localparam logic [addr_w-1:0] soc_end      = 32'h1FFF_FFFF;
  localparam logic [addr_w-1:0] c07_start    = 32'h2000_0000;
  localparam logic [addr_w-1:0] c07_end      = 32'h3FFF_FFFF;
  localparam logic [addr_w-1:0] nocr07_start = 32'h4000_0000;
  localparam logic [addr_w-1:0] nocr07_end   = 32'hFFFF_FFFF;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              we;
    logic [data_w-1:0] wdata;
    logic [iw_inp-1:0] id;
  } ini_req_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              we;
    logic [data_w-1:0] wdata;
    logic [iw_oup-1:0] id;
  } tgt_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              err;
    logic [iw_oup-1:0] id;
  } tgt_rsp_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              err;
    logic [iw_inp-1:0] id;
  } ini_rsp_t;

  // first set bit of hit, searching upward from ptr with wrap
  function automatic ini_idx_t rr_pick(input logic [n_ini-1:0] hit, input ini_idx_t ptr);
    ini_idx_t idx;
    ini_idx_t win;
    logic     found;
    win   = ptr;
    found = 1'b0;
    for (int i = 0; i < n_ini; i++) begin
      idx = ptr + ini_idx_t'(i);
      if (!found && hit[idx]) begin
        win   = idx;
        found = 1'b1;
      end
    end
    return win;
  endfunction

endpackage

`default_nettype wire

/* design/node_slice.sv */
/*
 * one-entry register slice
 * breaks the combinational path of a valid/ready channel, full throughput
 */
`timescale 1ns/10ps
`default_nettype none

module node_slice #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     arst_n,
  input  wire payload_t in_data,
  input  wire logic     in_valid,
  output logic          in_ready,
  output payload_t      out_data,
  output logic          out_valid,
  input  wire logic     out_ready
);

  logic     full_q;
  payload_t data_q;

  // take new data when empty or when the held item leaves this cycle
  assign in_ready = !full_q || out_ready;

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
    end else if (in_ready) begin
      // refill or drain
      full_q <= in_valid;
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full_q;
  assign out_data  = data_q;

endmodule

`default_nettype wire

/* design/node_addr_decode.sv */
/*
 * request address decoder
 * checks the address against the soc, c07 and nocr07 ranges in order
 * and returns the first matching target or the unmapped code
 */
`timescale 1ns/10ps
`default_nettype none

module node_addr_decode (
  input  wire logic [soc_node_pkg::addr_w-1:0] addr,
  output soc_node_pkg::dest_t                  dest
);

  logic hit_soc;
  logic hit_c07;
  logic hit_nocr07;

  // inclusive start/end compares
  assign hit_soc    = (addr >= soc_node_pkg::soc_start) && (addr <= soc_node_pkg::soc_end);
  assign hit_c07    = (addr >= soc_node_pkg::c07_start) && (addr <= soc_node_pkg::c07_end);
  assign hit_nocr07 = (addr >= soc_node_pkg::nocr07_start) &&
                      (addr <= soc_node_pkg::nocr07_end);

  always_comb begin
    // target order decides overlaps
    if (hit_soc) begin
      dest = soc_node_pkg::tgt_soc;
    end else if (hit_c07) begin
      dest = soc_node_pkg::tgt_c07;
    end else if (hit_nocr07) begin
      dest = soc_node_pkg::tgt_nocr07;
    end else begin
      // below soc_start, answered by the error target
      dest = soc_node_pkg::dest_none;
    end
  end

endmodule

`default_nettype wire

/* design/node_req_arbiter.sv */
/*
 * per-target request arbiter
 * round-robin over the initiators aimed at this target, holds the grant
 * while the output stalls, widens the id with the initiator index
 */
`timescale 1ns/10ps
`default_nettype none

module node_req_arbiter (
  input  wire logic                                         clk_i,
  input  wire logic                                         arst_n,
  input  wire soc_node_pkg::ini_req_t [soc_node_pkg::n_ini-1:0] req,
  input  wire logic [soc_node_pkg::n_ini-1:0]               req_hit,
  output logic [soc_node_pkg::n_ini-1:0]                    req_ready,
  output soc_node_pkg::tgt_req_t                            out_req,
  output logic                                              out_valid,
  input  wire logic                                         out_ready
);

  soc_node_pkg::ini_idx_t ptr_q;
  soc_node_pkg::ini_idx_t lock_idx_q;
  logic                   lock_q;
  soc_node_pkg::ini_idx_t win;
  logic                   xfer;

  always_comb begin
    // stalled grant wins over a fresh pick
    if (lock_q) begin
      win = lock_idx_q;
    end else begin
      win = soc_node_pkg::rr_pick(req_hit, ptr_q);
    end
  end

  // upstream slices keep valid up, so any hit means a request
  assign out_valid = |req_hit;
  assign xfer      = out_valid && out_ready;

  always_comb begin
    out_req.addr  = req[win].addr;
    out_req.we    = req[win].we;
    out_req.wdata = req[win].wdata;
    // initiator index above the original id
    out_req.id    = {win, req[win].id};
  end

  always_comb begin
    req_ready = '0;
    // only the winner sees the downstream ready
    if (out_valid) begin
      req_ready[win] = out_ready;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (xfer) begin
      // next search starts past the winner
      ptr_q  <= win + soc_node_pkg::ini_idx_t'(1);
      lock_q <= 1'b0;
    end else if (out_valid) begin
      // output stalled, freeze the choice
      lock_q     <= 1'b1;
      lock_idx_q <= win;
    end
  end

endmodule

`default_nettype wire

/* design/node_err_target.sv */
/*
 * error target
 * absorbs requests to unmapped addresses and answers each with err set
 */
`timescale 1ns/10ps
`default_nettype none

module node_err_target (
  input  wire logic                                           clk_i,
  input  wire logic                                           arst_n,
  input  wire logic [soc_node_pkg::n_ini-1:0]                 req_hit,
  input  wire logic [soc_node_pkg::n_ini-1:0][soc_node_pkg::iw_inp-1:0] req_id,
  output logic [soc_node_pkg::n_ini-1:0]                      req_ready,
  output soc_node_pkg::tgt_rsp_t                              rsp,
  output logic                                                rsp_valid,
  input  wire logic                                           rsp_ready
);

  logic                             full_q;
  logic [soc_node_pkg::iw_oup-1:0]  id_q;
  soc_node_pkg::ini_idx_t           ptr_q;
  soc_node_pkg::ini_idx_t           win;
  logic                             accept;
  logic                             take;

  // room when empty or when the pending answer leaves now
  assign accept = !full_q || rsp_ready;
  assign take   = accept && |req_hit;
  assign win    = soc_node_pkg::rr_pick(req_hit, ptr_q);

  always_comb begin
    req_ready = '0;
    if (take) begin
      req_ready[win] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
      ptr_q  <= '0;
    end else begin
      if (accept) begin
        full_q <= |req_hit;
      end
      if (take) begin
        ptr_q <= win + soc_node_pkg::ini_idx_t'(1);
      end
    end
  end

  // widened id of the pending request
  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q <= {win, req_id[win]};
    end
  end

  always_comb begin
    rsp.rdata = '0;
    rsp.err   = 1'b1;
    rsp.id    = id_q;
  end

  assign rsp_valid = full_q;

endmodule

`default_nettype wire

/* design/node_resp_router.sv */
/*
 * response router for one initiator
 * fixed-priority merge of the target and error responses whose id
 * top bits name this initiator, strips those bits on the way out
 */
`timescale 1ns/10ps
`default_nettype none

module node_resp_router (
  input  wire logic                                         clk_i,
  input  wire logic                                         arst_n,
  input  wire soc_node_pkg::ini_idx_t                       ini_idx,
  input  wire soc_node_pkg::tgt_rsp_t [soc_node_pkg::n_src-1:0] tgt_rsp,
  input  wire logic [soc_node_pkg::n_src-1:0]               tgt_rsp_valid,
  output logic [soc_node_pkg::n_src-1:0]                    tgt_rsp_ready,
  output soc_node_pkg::ini_rsp_t                            ini_rsp,
  output logic                                              ini_rsp_valid,
  input  wire logic                                         ini_rsp_ready
);

  logic [soc_node_pkg::n_src-1:0] match;
  soc_node_pkg::src_idx_t         sel;
  soc_node_pkg::src_idx_t         lock_src_q;
  logic                           lock_q;

  always_comb begin
    // sources addressed to this initiator
    for (int s = 0; s < soc_node_pkg::n_src; s++) begin
      match[s] = tgt_rsp_valid[s] &&
                 (tgt_rsp[s].id[soc_node_pkg::iw_oup-1:soc_node_pkg::iw_inp] == ini_idx);
    end
  end

  always_comb begin
    sel = '0;
    // lowest index wins, error target is last
    for (int s = soc_node_pkg::n_src - 1; s >= 0; s--) begin
      if (match[s]) begin
        sel = soc_node_pkg::src_idx_t'(s);
      end
    end
    // a stalled source keeps the path so its payload stays put
    if (lock_q) begin
      sel = lock_src_q;
    end
  end

  assign ini_rsp_valid = |match;

  always_comb begin
    ini_rsp.rdata = tgt_rsp[sel].rdata;
    ini_rsp.err   = tgt_rsp[sel].err;
    // original initiator id only
    ini_rsp.id    = tgt_rsp[sel].id[soc_node_pkg::iw_inp-1:0];
  end

  always_comb begin
    tgt_rsp_ready = '0;
    if (ini_rsp_valid) begin
      tgt_rsp_ready[sel] = ini_rsp_ready;
    end
  end

  // hold flag only, the data path stays combinational
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      lock_q     <= 1'b0;
      lock_src_q <= '0;
    end else if (ini_rsp_valid && !ini_rsp_ready) begin
      lock_q     <= 1'b1;
      lock_src_q <= sel;
    end else begin
      lock_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/soc_node.sv */
/*
 * soc interconnect node
 * four initiators to soc, c07 and nocr07 targets with address decode,
 * per-target round-robin, id widening and an error target for holes
 */
`timescale 1ns/10ps
`default_nettype none

module soc_node (
  input  wire logic                                             clk_i,
  input  wire logic                                             arst_n,
  // initiator ports
  input  wire soc_node_pkg::ini_req_t [soc_node_pkg::n_ini-1:0] ini_req,
  input  wire logic [soc_node_pkg::n_ini-1:0]                   ini_req_valid,
  output logic [soc_node_pkg::n_ini-1:0]                        ini_req_ready,
  output soc_node_pkg::ini_rsp_t [soc_node_pkg::n_ini-1:0]      ini_rsp,
  output logic [soc_node_pkg::n_ini-1:0]                        ini_rsp_valid,
  input  wire logic [soc_node_pkg::n_ini-1:0]                   ini_rsp_ready,
  // target ports
  output soc_node_pkg::tgt_req_t [soc_node_pkg::n_tgt-1:0]      tgt_req,
  output logic [soc_node_pkg::n_tgt-1:0]                        tgt_req_valid,
  input  wire logic [soc_node_pkg::n_tgt-1:0]                   tgt_req_ready,
  input  wire soc_node_pkg::tgt_rsp_t [soc_node_pkg::n_tgt-1:0] tgt_rsp,
  input  wire logic [soc_node_pkg::n_tgt-1:0]                   tgt_rsp_valid,
  output logic [soc_node_pkg::n_tgt-1:0]                        tgt_rsp_ready
);

  // registered initiator requests
  soc_node_pkg::ini_req_t [soc_node_pkg::n_ini-1:0] req_q;
  logic [soc_node_pkg::n_ini-1:0]                   req_q_valid;
  logic [soc_node_pkg::n_ini-1:0]                   req_q_ready;
  soc_node_pkg::dest_t [soc_node_pkg::n_ini-1:0]    req_dest;

  // arbiter and error target hooks
  logic [soc_node_pkg::n_tgt-1:0][soc_node_pkg::n_ini-1:0] arb_hit;
  logic [soc_node_pkg::n_tgt-1:0][soc_node_pkg::n_ini-1:0] arb_ready;
  soc_node_pkg::tgt_req_t [soc_node_pkg::n_tgt-1:0]        arb_req;
  logic [soc_node_pkg::n_tgt-1:0]                          arb_valid;
  logic [soc_node_pkg::n_tgt-1:0]                          arb_out_ready;
  logic [soc_node_pkg::n_ini-1:0]                          err_hit;
  logic [soc_node_pkg::n_ini-1:0]                          err_ready;
  logic [soc_node_pkg::n_ini-1:0][soc_node_pkg::iw_inp-1:0] err_req_id;

  // response sources, three targets then the error target
  soc_node_pkg::tgt_rsp_t [soc_node_pkg::n_src-1:0]        src_rsp;
  logic [soc_node_pkg::n_src-1:0]                          src_valid;
  logic [soc_node_pkg::n_src-1:0]                          src_ready;
  logic [soc_node_pkg::n_ini-1:0][soc_node_pkg::n_src-1:0] rtr_ready;

  for (genvar i = 0; i < soc_node_pkg::n_ini; i++) begin : g_ini
    node_slice #(
      .payload_t (soc_node_pkg::ini_req_t)
    ) u_req_slice (
      .clk_i     (clk_i),
      .arst_n    (arst_n),
      .in_data   (ini_req[i]),
      .in_valid  (ini_req_valid[i]),
      .in_ready  (ini_req_ready[i]),
      .out_data  (req_q[i]),
      .out_valid (req_q_valid[i]),
      .out_ready (req_q_ready[i])
    );

    node_addr_decode u_decode (
      .addr (req_q[i].addr),
      .dest (req_dest[i])
    );

    node_resp_router u_router (
      .clk_i         (clk_i),
      .arst_n        (arst_n),
      .ini_idx       (soc_node_pkg::ini_idx_t'(i)),
      .tgt_rsp       (src_rsp),
      .tgt_rsp_valid (src_valid),
      .tgt_rsp_ready (rtr_ready[i]),
      .ini_rsp       (ini_rsp[i]),
      .ini_rsp_valid (ini_rsp_valid[i]),
      .ini_rsp_ready (ini_rsp_ready[i])
    );
  end

  // steer each valid request to its arbiter or the error target
  always_comb begin
    for (int i = 0; i < soc_node_pkg::n_ini; i++) begin
      for (int t = 0; t < soc_node_pkg::n_tgt; t++) begin
        arb_hit[t][i] = req_q_valid[i] && (req_dest[i] == soc_node_pkg::dest_t'(t));
      end
      err_hit[i]    = req_q_valid[i] && (req_dest[i] == soc_node_pkg::dest_none);
      err_req_id[i] = req_q[i].id;
    end
  end

  // a request has one destination, so at most one ready is set
  always_comb begin
    for (int i = 0; i < soc_node_pkg::n_ini; i++) begin
      req_q_ready[i] = err_ready[i];
      for (int t = 0; t < soc_node_pkg::n_tgt; t++) begin
        req_q_ready[i] = req_q_ready[i] | arb_ready[t][i];
      end
    end
  end

  for (genvar t = 0; t < soc_node_pkg::n_tgt; t++) begin : g_tgt
    node_req_arbiter u_arbiter (
      .clk_i     (clk_i),
      .arst_n    (arst_n),
      .req       (req_q),
      .req_hit   (arb_hit[t]),
      .req_ready (arb_ready[t]),
      .out_req   (arb_req[t]),
      .out_valid (arb_valid[t]),
      .out_ready (arb_out_ready[t])
    );

    node_slice #(
      .payload_t (soc_node_pkg::tgt_req_t)
    ) u_tgt_slice (
      .clk_i     (clk_i),
      .arst_n    (arst_n),
      .in_data   (arb_req[t]),
      .in_valid  (arb_valid[t]),
      .in_ready  (arb_out_ready[t]),
      .out_data  (tgt_req[t]),
      .out_valid (tgt_req_valid[t]),
      .out_ready (tgt_req_ready[t])
    );
  end

  node_err_target u_err_target (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .req_hit   (err_hit),
    .req_id    (err_req_id),
    .req_ready (err_ready),
    .rsp       (src_rsp[soc_node_pkg::src_err]),
    .rsp_valid (src_valid[soc_node_pkg::src_err]),
    .rsp_ready (src_ready[soc_node_pkg::src_err])
  );

  assign src_rsp[soc_node_pkg::n_tgt-1:0]   = tgt_rsp;
  assign src_valid[soc_node_pkg::n_tgt-1:0] = tgt_rsp_valid;
  assign tgt_rsp_ready                      = src_ready[soc_node_pkg::n_tgt-1:0];

  // only the router named in the id top bits can pick a source
  always_comb begin
    src_ready = '0;
    for (int i = 0; i < soc_node_pkg::n_ini; i++) begin
      src_ready = src_ready | rtr_ready[i];
    end
  end

endmodule

`default_nettype wire

/* tb/soc_node_sva.sv */
/*
 * soc node output handshake assertions
 * valid holds with a stable payload until ready, idle after reset
 */
`timescale 1ns/10ps
`default_nettype none

module soc_node_sva (
  input wire logic                                             clk_i,
  input wire logic                                             arst_n,
  input wire soc_node_pkg::tgt_req_t [soc_node_pkg::n_tgt-1:0] tgt_req,
  input wire logic [soc_node_pkg::n_tgt-1:0]                   tgt_req_valid,
  input wire logic [soc_node_pkg::n_tgt-1:0]                   tgt_req_ready,
  input wire soc_node_pkg::ini_rsp_t [soc_node_pkg::n_ini-1:0] ini_rsp,
  input wire logic [soc_node_pkg::n_ini-1:0]                   ini_rsp_valid,
  input wire logic [soc_node_pkg::n_ini-1:0]                   ini_rsp_ready
);

  for (genvar t = 0; t < soc_node_pkg::n_tgt; t++) begin : g_tgt
    // stalled request stays put
    tgt_req_hold : assert property (@(posedge clk_i) disable iff (!arst_n)
      tgt_req_valid[t] && !tgt_req_ready[t] |=> tgt_req_valid[t] && $stable(tgt_req[t]))
      else $error("target %0d request dropped or changed while stalled", t);
  end

  for (genvar i = 0; i < soc_node_pkg::n_ini; i++) begin : g_ini
    ini_rsp_hold : assert property (@(posedge clk_i) disable iff (!arst_n)
      ini_rsp_valid[i] && !ini_rsp_ready[i] |=> ini_rsp_valid[i] && $stable(ini_rsp[i]))
      else $error("initiator %0d response dropped or changed while stalled", i);
  end

  // first edge after release sees no valid output
  reset_idle : assert property (@(posedge clk_i)
    $rose(arst_n) |-> (tgt_req_valid == '0) && (ini_rsp_valid == '0))
    else $error("output valid high right after reset release");

endmodule

bind soc_node soc_node_sva u_sva (
  .clk_i         (clk_i),
  .arst_n        (arst_n),
  .tgt_req       (tgt_req),
  .tgt_req_valid (tgt_req_valid),
  .tgt_req_ready (tgt_req_ready),
  .ini_rsp       (ini_rsp),
  .ini_rsp_valid (ini_rsp_valid),
  .ini_rsp_ready (ini_rsp_ready)
);

`default_nettype wire

/* tb/soc_node_tb.sv */
/*
 * soc node testbench
 * random traffic from four initiators into echoing target models,
 * every target request and initiator response checked against a reference
 */
`timescale 1ns/10ps
`default_nettype none

module soc_node_tb;

  localparam int n_ini  = soc_node_pkg::n_ini;
  localparam int n_tgt  = soc_node_pkg::n_tgt;
  localparam int iwi    = soc_node_pkg::iw_inp;
  localparam int iwo    = soc_node_pkg::iw_oup;
  localparam int n_id   = 1 << iwi;
  // random traffic first, then back-to-back contention on soc
  localparam int n_rand = 40;
  localparam int n_cont = 12;
  localparam int n_per  = n_rand + n_cont;
  localparam int max_cyc = 40 * n_ini * n_per + 200;

  logic                                   clk_i;
  logic                                   arst_n;
  soc_node_pkg::ini_req_t [n_ini-1:0]     ini_req;
  logic [n_ini-1:0]                       ini_req_valid;
  logic [n_ini-1:0]                       ini_req_ready;
  soc_node_pkg::ini_rsp_t [n_ini-1:0]     ini_rsp;
  logic [n_ini-1:0]                       ini_rsp_valid;
  logic [n_ini-1:0]                       ini_rsp_ready;
  soc_node_pkg::tgt_req_t [n_tgt-1:0]     tgt_req;
  logic [n_tgt-1:0]                       tgt_req_valid;
  logic [n_tgt-1:0]                       tgt_req_ready;
  soc_node_pkg::tgt_rsp_t [n_tgt-1:0]     tgt_rsp;
  logic [n_tgt-1:0]                       tgt_rsp_valid;
  logic [n_tgt-1:0]                       tgt_rsp_ready;

  // scoreboard indexed by initiator and original id
  logic [n_id-1:0]        busy [n_ini];
  logic [n_id-1:0]        pend_req [n_ini];
  logic [1:0]             exp_dest [n_ini][n_id];
  soc_node_pkg::tgt_req_t exp_req [n_ini][n_id];
  soc_node_pkg::ini_rsp_t exp_rsp [n_ini][n_id];
  int                     issued [n_ini];
  // requests accepted by each target model, answered in order
  soc_node_pkg::tgt_req_t tgt_q [n_tgt][$];
  // handshakes seen at the last rising edge
  logic [n_ini-1:0]       req_fire;
  logic [n_ini-1:0]       rsp_fire;
  logic [n_tgt-1:0]       tgt_req_fire;
  logic [n_tgt-1:0]       tgt_rsp_fire;
  logic [31:0]            lfsr_q;
  int                     cycles;
  int                     left;

  soc_node u_dut (.*);

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v[b]   = lfsr_q[0];
    end
    return v;
  endfunction

  // 0 is the unmapped hole, 1..3 are soc, c07, nocr07
  function automatic logic [31:0] pick_addr(input logic [1:0] sel);
    logic [31:0] r;
    r = rand_bits(32);
    case (sel)
      2'd0: return r % soc_node_pkg::soc_start;
      2'd1: return soc_node_pkg::soc_start +
                   r % (soc_node_pkg::soc_end - soc_node_pkg::soc_start + 1);
      2'd2: return soc_node_pkg::c07_start +
                   r % (soc_node_pkg::c07_end - soc_node_pkg::c07_start + 1);
      default: return soc_node_pkg::nocr07_start +
                      r % (soc_node_pkg::nocr07_end - soc_node_pkg::nocr07_start + 1);
    endcase
  endfunction

  function automatic void expected_rsp(
    input  int                     ini,
    input  soc_node_pkg::ini_req_t req,
    output logic [1:0]             dest,
    output logic [iwo-1:0]         wid,
    output soc_node_pkg::ini_rsp_t rsp
  );
    if (req.addr >= soc_node_pkg::soc_start && req.addr <= soc_node_pkg::soc_end) begin
      dest = 2'd0;
    end else if (req.addr >= soc_node_pkg::c07_start && req.addr <= soc_node_pkg::c07_end) begin
      dest = 2'd1;
    end else if (req.addr >= soc_node_pkg::nocr07_start) begin
      dest = 2'd2;
    end else begin
      dest = 2'd3;
    end
    wid    = {soc_node_pkg::ini_idx_t'(ini), req.id};
    rsp.id = req.id;
    if (dest == 2'd3) begin
      // holes are answered by the node itself
      rsp.rdata = '0;
      rsp.err   = 1'b1;
    end else begin
      rsp.rdata = req.addr ^ (32'(dest) * 32'h0101_0101);
      rsp.err   = 1'b0;
    end
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    if (exp !== act) begin
      $display("error %s expected %0h actual %0h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // compare every handshake against the scoreboard
  always @(posedge clk_i) begin : compare
    int src;
    int id;
    req_fire     = ini_req_valid & ini_req_ready;
    rsp_fire     = ini_rsp_valid & ini_rsp_ready;
    tgt_req_fire = tgt_req_valid & tgt_req_ready;
    tgt_rsp_fire = tgt_rsp_valid & tgt_rsp_ready;
    for (int t = 0; t < n_tgt; t++) begin
      if (tgt_req_fire[t]) begin
        src = tgt_req[t].id[iwo-1:iwi];
        id  = tgt_req[t].id[iwi-1:0];
        check_value("request outstanding", 1, pend_req[src][id]);
        check_value("route target", exp_dest[src][id], t);
        check_value("route payload", exp_req[src][id], tgt_req[t]);
        pend_req[src][id] = 1'b0;
        tgt_q[t].push_back(tgt_req[t]);
      end
    end
    for (int i = 0; i < n_ini; i++) begin
      if (rsp_fire[i]) begin
        id = ini_rsp[i].id;
        check_value("response outstanding", 1, busy[i][id] & ~pend_req[i][id]);
        check_value("response payload", exp_rsp[i][id], ini_rsp[i]);
        busy[i][id] = 1'b0;
      end
    end
  end

  // target models and initiators, all driven on the falling edge
  always @(negedge clk_i) begin : drive
    logic [iwi-1:0]         id;
    logic                   found;
    logic [1:0]             sel;
    logic [1:0]             dest;
    logic [iwo-1:0]         wid;
    soc_node_pkg::ini_req_t req;
    soc_node_pkg::ini_rsp_t rsp;
    soc_node_pkg::tgt_req_t treq;
    if (arst_n) begin
      for (int t = 0; t < n_tgt; t++) begin
        tgt_req_ready[t] = rand_bits(2) != 2'd0;
        if (tgt_rsp_fire[t]) begin
          tgt_rsp_valid[t] = 1'b0;
        end
        // answer the oldest request after a random gap
        if (!tgt_rsp_valid[t] && tgt_q[t].size() > 0 && rand_bits(1) == 1) begin
          treq             = tgt_q[t].pop_front();
          tgt_rsp[t].rdata = treq.addr ^ (32'(t) * 32'h0101_0101);
          tgt_rsp[t].err   = 1'b0;
          tgt_rsp[t].id    = treq.id;
          tgt_rsp_valid[t] = 1'b1;
        end
      end
      for (int i = 0; i < n_ini; i++) begin
        ini_rsp_ready[i] = rand_bits(2) != 2'd0;
        if (req_fire[i]) begin
          ini_req_valid[i] = 1'b0;
        end
        if (!ini_req_valid[i] && issued[i] < n_per &&
            (issued[i] >= n_rand || rand_bits(1) == 1)) begin
          // first free id from a random start
          id    = iwi'(rand_bits(iwi));
          found = 1'b0;
          for (int k = 0; k < n_id; k++) begin
            if (!found && !busy[i][iwi'(id + k)]) begin
              found = 1'b1;
              id    = iwi'(id + k);
            end
          end
          if (found) begin
            sel       = (issued[i] >= n_rand) ? 2'd1 : 2'(rand_bits(2));
            req.addr  = pick_addr(sel);
            req.we    = 1'(rand_bits(1));
            req.wdata = rand_bits(32);
            req.id    = id;
            expected_rsp(i, req, dest, wid, rsp);
            exp_dest[i][id]       = dest;
            exp_req[i][id].addr   = req.addr;
            exp_req[i][id].we     = req.we;
            exp_req[i][id].wdata  = req.wdata;
            exp_req[i][id].id     = wid;
            exp_rsp[i][id]        = rsp;
            busy[i][id]           = 1'b1;
            pend_req[i][id]       = (dest != 2'd3);
            ini_req[i]            = req;
            ini_req_valid[i]      = 1'b1;
            issued[i]             = issued[i] + 1;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= max_cyc) begin
      $display("CHECKS FAILED");
      $fatal(1, "timeout after %0d cycles with traffic still outstanding", cycles);
    end
  end

  function automatic logic run_done();
    logic done;
    done = 1'b1;
    for (int i = 0; i < n_ini; i++) begin
      if (issued[i] != n_per || busy[i] != '0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  initial begin
    arst_n        = 1'b0;
    lfsr_q        = 32'hcf28_1623;
    cycles        = 0;
    ini_req       = '0;
    ini_req_valid = '0;
    ini_rsp_ready = '0;
    tgt_req_ready = '0;
    tgt_rsp       = '0;
    tgt_rsp_valid = '0;
    req_fire      = '0;
    rsp_fire      = '0;
    tgt_req_fire  = '0;
    tgt_rsp_fire  = '0;
    for (int i = 0; i < n_ini; i++) begin
      busy[i]     = '0;
      pend_req[i] = '0;
      issued[i]   = 0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n <= 1'b1;
    while (!run_done()) begin
      @(negedge clk_i);
    end
    // with every response back the node must show no valid output
    @(posedge clk_i);
    left = $countones(tgt_req_valid) + $countones(ini_rsp_valid);
    if (left == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "%0d output valids still high at the end of the run", left);
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
design/soc_node_pkg.sv
design/node_slice.sv
design/node_addr_decode.sv
design/node_req_arbiter.sv
design/node_err_target.sv
design/node_resp_router.sv
design/soc_node.sv
tb/soc_node_sva.sv
tb/soc_node_tb.sv
